//--- filelist.f
source/merge_pkg.sv
source/fifo_rd_if.sv
source/sync_fifo.sv
source/rr_merge.sv
source/dual_lane_merge.sv
verification/clk_gen.sv
verification/tb_dual_lane_merge.sv

//--- verification/tb_dual_lane_merge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dual_lane_merge;

    localparam int TIMEOUT_CYCLES = 2000;   // Roughly four times the phases below

    logic              clk;
    logic              rst_n;
    logic              wr_en_a;
    merge_pkg::data_t  wr_data_a;
    logic              wr_en_b;
    merge_pkg::data_t  wr_data_b;
    logic              full_a;
    logic              full_b;
    logic              overflow_a;
    logic              overflow_b;
    logic              out_valid;
    merge_pkg::data_t  out_data;
    merge_pkg::lane_e  out_lane;

    // Reference model state
    merge_pkg::data_t  qa [$];
    merge_pkg::data_t  qb [$];
    merge_pkg::lane_e  last_lane = merge_pkg::LANE_B;
    int                cnt_a = 0;
    int                cnt_b = 0;
    logic              exp_valid = 1'b0;
    merge_pkg::data_t  exp_data = '0;
    merge_pkg::lane_e  exp_lane = merge_pkg::LANE_A;
    logic              exp_full_a;
    logic              exp_full_b;
    logic              exp_ovf_a;
    logic              exp_ovf_b;
    int                n_accepted = 0;
    int                n_seen = 0;
    int                cycle_count = 0;
    logic [31:0]       rng_state = 32'd77669;

    clk_gen clk_gen_inst (
        .clk (clk)
    );

    dual_lane_merge dual_lane_merge_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en_a    (wr_en_a),
        .wr_data_a  (wr_data_a),
        .wr_en_b    (wr_en_b),
        .wr_data_b  (wr_data_b),
        .full_a     (full_a),
        .full_b     (full_b),
        .overflow_a (overflow_a),
        .overflow_b (overflow_b),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_lane   (out_lane)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Status the model expects in the current cycle
    assign exp_full_a = (cnt_a == merge_pkg::FIFO_DEPTH);
    assign exp_full_b = (cnt_b == merge_pkg::FIFO_DEPTH);
    assign exp_ovf_a  = wr_en_a && exp_full_a;
    assign exp_ovf_b  = wr_en_b && exp_full_b;

    // Cycle model of both lanes and the merger
    always @(posedge clk or negedge rst_n) begin : model_step
        logic take_a;
        logic take_b;
        logic push_a;
        logic push_b;
        logic af_a;
        logic af_b;
        if (!rst_n) begin
            qa.delete();
            qb.delete();
            last_lane = merge_pkg::LANE_B;
            cnt_a     <= 0;
            cnt_b     <= 0;
            exp_valid <= 1'b0;
        end else begin
            af_a   = qa.size() > merge_pkg::AFULL_LEVEL;
            af_b   = qb.size() > merge_pkg::AFULL_LEVEL;
            push_a = wr_en_a && (qa.size() < merge_pkg::FIFO_DEPTH);
            push_b = wr_en_b && (qb.size() < merge_pkg::FIFO_DEPTH);
            take_a = 1'b0;
            take_b = 1'b0;
            if (qa.size() > 0 && qb.size() > 0) begin
                if (af_a != af_b) begin
                    take_a = af_a;                    // Nearly full lane first
                    take_b = af_b;
                end else begin
                    take_a = (last_lane == merge_pkg::LANE_B);
                    take_b = !take_a;
                end
            end else begin
                take_a = qa.size() > 0;
                take_b = qb.size() > 0;
            end
            exp_valid <= take_a || take_b;
            if (take_a) begin
                exp_data  <= qa.pop_front();
                exp_lane  <= merge_pkg::LANE_A;
                last_lane = merge_pkg::LANE_A;
            end else if (take_b) begin
                exp_data  <= qb.pop_front();
                exp_lane  <= merge_pkg::LANE_B;
                last_lane = merge_pkg::LANE_B;
            end
            if (push_a) qa.push_back(wr_data_a);
            if (push_b) qb.push_back(wr_data_b);
            n_accepted <= n_accepted + int'(push_a) + int'(push_b);
            cnt_a      <= qa.size();
            cnt_b      <= qb.size();
        end
    end

    chk_out_valid: assert property (@(posedge clk) out_valid == exp_valid)
        else report_mismatch("out_valid", $sampled(out_valid), $sampled(exp_valid));
    chk_out_data: assert property (@(posedge clk) out_valid |-> out_data == exp_data)
        else report_mismatch("out_data", $sampled(out_data), $sampled(exp_data));
    chk_out_lane: assert property (@(posedge clk) out_valid |-> out_lane == exp_lane)
        else report_mismatch("out_lane", $sampled(out_lane), $sampled(exp_lane));
    chk_full_a: assert property (@(posedge clk) full_a == exp_full_a)
        else report_mismatch("full_a", $sampled(full_a), $sampled(exp_full_a));
    chk_full_b: assert property (@(posedge clk) full_b == exp_full_b)
        else report_mismatch("full_b", $sampled(full_b), $sampled(exp_full_b));
    chk_ovf_a: assert property (@(posedge clk) overflow_a == exp_ovf_a)
        else report_mismatch("overflow_a", $sampled(overflow_a), $sampled(exp_ovf_a));
    chk_ovf_b: assert property (@(posedge clk) overflow_b == exp_ovf_b)
        else report_mismatch("overflow_b", $sampled(overflow_b), $sampled(exp_ovf_b));

    // Only lane A nearly full while both hold data
    chk_priority: assert property (@(posedge clk)
        (cnt_a > merge_pkg::AFULL_LEVEL && cnt_b > 0 && cnt_b <= merge_pkg::AFULL_LEVEL)
        |=> (out_valid && out_lane == merge_pkg::LANE_A))
        else abort_run("lane A was almost full but was not served first");

    always @(negedge clk) begin
        if (rst_n && out_valid) n_seen <= n_seen + 1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the test did not finish within the cycle limit");
        end
    end

    task automatic drive_cycle(input logic en_a, input merge_pkg::data_t d_a,
                               input logic en_b, input merge_pkg::data_t d_b);
        @(negedge clk);
        wr_en_a   = en_a;
        wr_data_a = d_a;
        wr_en_b   = en_b;
        wr_data_b = d_b;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    // Until both lanes and the output stage are empty
    task automatic wait_drain();
        idle_cycles(1);
        while (cnt_a != 0 || cnt_b != 0 || exp_valid) begin
            idle_cycles(1);
        end
        idle_cycles(1);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        int          i;
        logic        seen_a;
        logic        seen_b;
        rst_n     <= 1'b0;
        wr_en_a   = 1'b0;
        wr_data_a = '0;
        wr_en_b   = 1'b0;
        wr_data_b = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(2);

        // Lane A alone with gaps
        for (i = 0; i < 4; i++) begin
            r = next_rand();
            drive_cycle(1'b1, r[7:0], 1'b0, '0);
            idle_cycles(2);
        end
        wait_drain();

        // One word on B so the next tie goes to A
        r = next_rand();
        drive_cycle(1'b0, '0, 1'b1, r[7:0]);
        wait_drain();
        for (i = 0; i < 3; i++) begin
            r = next_rand();
            drive_cycle(1'b1, r[7:0], 1'b1, r[15:8]);
        end
        wait_drain();

        // A every cycle, B every second cycle
        i = 0;
        while (cnt_a <= merge_pkg::AFULL_LEVEL || i < 30) begin
            r = next_rand();
            drive_cycle(1'b1, r[7:0], (i % 2) == 0, r[15:8]);
            i++;
        end
        wait_drain();

        // Fill both lanes and push on into overflow
        seen_a = 1'b0;
        seen_b = 1'b0;
        while (!(seen_a && seen_b)) begin
            r = next_rand();
            drive_cycle(1'b1, r[7:0], 1'b1, r[15:8]);
            seen_a |= (cnt_a == merge_pkg::FIFO_DEPTH);
            seen_b |= (cnt_b == merge_pkg::FIFO_DEPTH);
        end
        for (i = 0; i < 6; i++) begin
            r = next_rand();
            drive_cycle(1'b1, r[7:0], 1'b1, r[15:8]);
        end
        wait_drain();

        // Random traffic at about 1.2 words offered per cycle
        for (i = 0; i < 300; i++) begin
            r = next_rand();
            drive_cycle(r[0] | r[1], r[15:8], r[2] & ~r[3] | r[4] & r[5], r[23:16]);
        end
        wait_drain();

        if (n_seen != n_accepted || qa.size() != 0 || qb.size() != 0) begin
            abort_run($sformatf("error: words out 0x%0h, words accepted 0x%0h",
                                n_seen, n_accepted));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule : tb_dual_lane_merge

`default_nettype wire

//--- verification/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
    output logic clk
);

    localparam time HALF_PERIOD = 50ns;   // 100 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule : clk_gen

`default_nettype wire

//--- source/dual_lane_merge.sv
`timescale 1ns/10ps
`default_nettype none

module dual_lane_merge (
    input  logic              clk,
    input  logic              rst_n,

    // Lane A write port
    input  logic              wr_en_a,
    input  merge_pkg::data_t  wr_data_a,

    // Lane B write port
    input  logic              wr_en_b,
    input  merge_pkg::data_t  wr_data_b,

    // Lane status
    output logic              full_a,
    output logic              full_b,
    output logic              overflow_a,
    output logic              overflow_b,

    // Merged stream
    output logic              out_valid,
    output merge_pkg::data_t  out_data,
    output merge_pkg::lane_e  out_lane
);

    fifo_rd_if rd_a ();
    fifo_rd_if rd_b ();

    sync_fifo fifo_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en_a),
        .wr_data  (wr_data_a),
        .full     (full_a),
        .overflow (overflow_a),
        .rd       (rd_a.fifo_side)
    );

    sync_fifo fifo_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en_b),
        .wr_data  (wr_data_b),
        .full     (full_b),
        .overflow (overflow_b),
        .rd       (rd_b.fifo_side)
    );

    // One pop per cycle across both lanes
    rr_merge merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .lane_a    (rd_a.reader_side),
        .lane_b    (rd_b.reader_side),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_lane  (out_lane)
    );

endmodule : dual_lane_merge

`default_nettype wire

//--- source/rr_merge.sv
`timescale 1ns/10ps
`default_nettype none

module rr_merge (
    input  logic              clk,
    input  logic              rst_n,
    fifo_rd_if.reader_side    lane_a,
    fifo_rd_if.reader_side    lane_b,
    output logic              out_valid,
    output merge_pkg::data_t  out_data,
    output merge_pkg::lane_e  out_lane
);

    merge_pkg::lane_e  last_served;
    merge_pkg::lane_e  sel_lane;
    logic              sel_valid;
    logic              avail_a;
    logic              avail_b;

    assign avail_a = !lane_a.empty;
    assign avail_b = !lane_b.empty;

    // Lane choice for this cycle
    always_comb begin
        sel_valid = 1'b0;
        sel_lane  = merge_pkg::LANE_A;
        if (avail_a && avail_b) begin
            sel_valid = 1'b1;
            if (lane_a.almost_full != lane_b.almost_full) begin
                // Nearly full lane goes first
                sel_lane = lane_a.almost_full ? merge_pkg::LANE_A : merge_pkg::LANE_B;
            end else if (last_served == merge_pkg::LANE_A) begin
                sel_lane = merge_pkg::LANE_B;
            end else begin
                sel_lane = merge_pkg::LANE_A;
            end
        end else if (avail_a) begin
            sel_valid = 1'b1;
            sel_lane  = merge_pkg::LANE_A;
        end else if (avail_b) begin
            sel_valid = 1'b1;
            sel_lane  = merge_pkg::LANE_B;
        end
    end

    assign lane_a.rd_en = sel_valid && (sel_lane == merge_pkg::LANE_A);
    assign lane_b.rd_en = sel_valid && (sel_lane == merge_pkg::LANE_B);

    // Round-robin history, lane A wins the first tie
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_served <= merge_pkg::LANE_B;
        end else if (sel_valid) begin
            last_served <= sel_lane;
        end
    end

    // Output stage lines up with the FIFO read register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_lane  <= merge_pkg::LANE_A;
        end else begin
            out_valid <= sel_valid;
            if (sel_valid) begin
                out_lane <= sel_lane;
            end
        end
    end

    // Head word of the lane popped last cycle
    assign out_data = (out_lane == merge_pkg::LANE_A) ? lane_a.rd_data : lane_b.rd_data;

endmodule : rr_merge

`default_nettype wire

//--- source/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  merge_pkg::data_t  wr_data,
    output logic              full,
    output logic              overflow,
    fifo_rd_if.fifo_side      rd
);

    merge_pkg::data_t   mem [merge_pkg::FIFO_DEPTH];
    merge_pkg::ptr_t    wr_ptr;
    merge_pkg::ptr_t    rd_ptr;
    merge_pkg::count_t  count;

    logic wr_ok;
    logic rd_ok;

    assign wr_ok = wr_en && !full;
    // Merger only pops a non-empty lane
    assign rd_ok = rd.rd_en;

    // Write pointer, wraps at the last entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            if (wr_ptr == merge_pkg::ptr_t'(merge_pkg::FIFO_DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Read pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_ok) begin
            if (rd_ptr == merge_pkg::ptr_t'(merge_pkg::FIFO_DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle, or push and pop together
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Registered head word
    always_ff @(posedge clk) begin
        if (rd_ok) begin
            rd.rd_data <= mem[rd_ptr];
        end
    end

    // Status decoded from the count
    assign full           = (count == merge_pkg::count_t'(merge_pkg::FIFO_DEPTH));
    assign rd.empty       = (count == '0);
    assign rd.almost_full = (count > merge_pkg::count_t'(merge_pkg::AFULL_LEVEL));

    // Dropped write
    assign overflow = wr_en && full;

endmodule : sync_fifo

`default_nettype wire

//--- source/fifo_rd_if.sv
`timescale 1ns/10ps
`default_nettype none

// Read side of one lane FIFO
interface fifo_rd_if;

    logic                rd_en;       // Pop request from the merger
    merge_pkg::data_t    rd_data;     // Head word, valid the edge after rd_en
    logic                empty;
    logic                almost_full;

    // FIFO end
    modport fifo_side (
        input  rd_en,
        output rd_data,
        output empty,
        output almost_full
    );

    // Merger end
    modport reader_side (
        output rd_en,
        input  rd_data,
        input  empty,
        input  almost_full
    );

endinterface : fifo_rd_if

`default_nettype wire

//--- source/merge_pkg.sv
`default_nettype none

package merge_pkg;

    // Word and buffer geometry
    localparam int DATA_WIDTH  = 8;
    localparam int FIFO_DEPTH  = 8;
    localparam int ADDR_WIDTH  = 3;

    // Count above this level raises almost_full (7 or 8 entries)
    localparam int AFULL_LEVEL = 6;

    // One byte of stream payload
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Read or write pointer into the storage array
    typedef logic [ADDR_WIDTH-1:0] ptr_t;

    // Occupancy, needs one extra bit to reach FIFO_DEPTH
    typedef logic [ADDR_WIDTH:0]   count_t;

    // Source lane of a merged word
    typedef enum logic {
        LANE_A = 1'b0,
        LANE_B = 1'b1
    } lane_e;

endpackage : merge_pkg

`default_nettype wire
